// File: design/fm_pkg.sv
// fm register interface definitions
`default_nettype none

package fm_pkg;

    localparam int num_ch      = 6;
    localparam int num_op      = 4;
    localparam int num_slot    = num_ch * num_op;
    localparam int busy_ticks  = 32;    // busy length in synth ticks
    localparam int tb_prescale = 16;    // timer b step every 16 ticks

    // global register map
    typedef enum logic [7:0] {
        lfo     = 8'h22,
        clka1   = 8'h24,
        clka2   = 8'h25,
        clkb    = 8'h26,
        timer   = 8'h27,
        kon     = 8'h28,
        pcm     = 8'h2A,
        pcm_en  = 8'h2B,
        dactest = 8'h2C,
        clk_n6  = 8'h2D,
        clk_n3  = 8'h2E,
        clk_n2  = 8'h2F
    } fm_reg_e;

    // which storage an update strobe hits
    typedef enum logic [3:0] {
        upd_none,
        upd_dt1_mul,
        upd_tl,
        upd_ks_ar,
        upd_am_d1r,
        upd_d2r,
        upd_sl_rr,
        upd_fnum_lo,
        upd_fb_alg,
        upd_lr_ams_pms,
        upd_keyon
    } fm_upd_e;

    typedef struct packed {
        fm_upd_e    target;
        logic [2:0] ch;         // {bank, reg[1:0]}, codes 0-2 and 4-6
        logic [1:0] op;         // reg[3:2], chip order s1 s3 s2 s4
        logic [7:0] data;
        logic [5:0] fnum_hi;    // {block, fnum[10:8]}
    } fm_update_t;

    typedef struct packed {
        logic [9:0] value_a;
        logic [7:0] value_b;
        logic       load_a;
        logic       load_b;
        logic       irq_en_a;
        logic       irq_en_b;
        logic       clr_a;
        logic       clr_b;
    } fm_timer_cfg_t;

    typedef struct packed {
        logic       lfo_en;
        logic [2:0] lfo_freq;
        logic [8:0] pcm;
        logic       pcm_en;
    } fm_global_t;

    typedef struct packed {
        logic [2:0]  ch;
        logic [1:0]  op;
        logic        keyon;
        logic [10:0] fnum;
        logic [2:0]  block;
        logic [2:0]  dt1;
        logic [3:0]  mul;
        logic [6:0]  tl;
        logic [1:0]  ks;
        logic [4:0]  ar;
        logic        amen;
        logic [4:0]  d1r;
        logic [4:0]  d2r;
        logic [3:0]  sl;
        logic [3:0]  rr;
        logic [2:0]  fb;
        logic [2:0]  alg;
        logic [1:0]  rl;
        logic [1:0]  ams;
        logic [2:0]  pms;
    } fm_slot_t;

endpackage

`default_nettype wire

// File: design/fm_mmr.sv
// fm memory-mapped register block
`timescale 1ns/1ns
`default_nettype none

module fm_mmr (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    cen,
    input  wire [7:0]              din,
    input  wire [1:0]              addr,
    input  wire                    write,
    output logic                   clk_en,
    output logic                   busy,
    output fm_pkg::fm_update_t     upd,
    output fm_pkg::fm_timer_cfg_t  tcfg,
    output fm_pkg::fm_global_t     glb
);

    logic [2:0] cen_cnt;
    logic [2:0] cen_lim;        // divide by cen_lim + 1
    logic [7:0] sel_reg;
    logic [5:0] fnum_hi_q;      // shared by all channels
    logic       data_wr;

    fm_pkg::fm_upd_e upd_target;
    logic [2:0]      upd_ch;
    logic [1:0]      upd_op;
    logic [7:0]      upd_data;
    logic [5:0]      upd_fnum_hi;

    logic [$clog2(fm_pkg::busy_ticks)-1:0] busy_cnt;

    // map a selected register to its update target
    function automatic fm_pkg::fm_upd_e decode_upd(input logic [7:0] r);
        fm_pkg::fm_upd_e t;
        t = fm_pkg::upd_none;
        if (r == fm_pkg::kon) begin
            t = fm_pkg::upd_keyon;
        end else if (r[1:0] != 2'b11) begin   // xx3h/xx7h/... hold no channel
            case (r[7:4])
                4'h3: t = fm_pkg::upd_dt1_mul;
                4'h4: t = fm_pkg::upd_tl;
                4'h5: t = fm_pkg::upd_ks_ar;
                4'h6: t = fm_pkg::upd_am_d1r;
                4'h7: t = fm_pkg::upd_d2r;
                4'h8: t = fm_pkg::upd_sl_rr;
                4'hA: begin
                    if (r[3:2] == 2'd0)
                        t = fm_pkg::upd_fnum_lo;   // a4h-a6h only feed the latch
                end
                4'hB: begin
                    if (r[3:2] == 2'd0)
                        t = fm_pkg::upd_fb_alg;
                    else if (r[3:2] == 2'd1)
                        t = fm_pkg::upd_lr_ams_pms;
                end
                default: t = fm_pkg::upd_none;
            endcase
        end
        return t;
    endfunction

    assign data_wr = write & addr[0];

    // clock enable divider
    always_ff @(posedge clk) begin
        if (rst) begin
            cen_cnt <= '0;
            clk_en  <= 1'b0;
        end else begin
            clk_en <= 1'b0;
            if (cen) begin
                if (cen_cnt >= cen_lim) begin   // >= covers a limit lowered mid-count
                    cen_cnt <= '0;
                    clk_en  <= 1'b1;
                end else begin
                    cen_cnt <= cen_cnt + 3'd1;
                end
            end
        end
    end

    // address latch and global registers
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_reg   <= '0;
            cen_lim   <= 3'd5;
            fnum_hi_q <= '0;
            tcfg      <= '0;
            glb       <= '0;
        end else begin
            if (clk_en) begin
                tcfg.clr_a <= 1'b0;     // clears last until the next tick
                tcfg.clr_b <= 1'b0;
            end
            if (write && !addr[0]) begin
                sel_reg <= din;
            end else if (data_wr) begin
                case (sel_reg)
                    fm_pkg::lfo:     {glb.lfo_en, glb.lfo_freq} <= din[3:0];
                    fm_pkg::clka1:   tcfg.value_a[9:2] <= din;
                    fm_pkg::clka2:   tcfg.value_a[1:0] <= din[1:0];
                    fm_pkg::clkb:    tcfg.value_b <= din;
                    fm_pkg::timer: begin
                        {tcfg.clr_b, tcfg.clr_a} <= din[5:4];
                        {tcfg.irq_en_b, tcfg.irq_en_a} <= din[3:2];
                        {tcfg.load_b, tcfg.load_a} <= din[1:0];
                    end
                    fm_pkg::pcm:     glb.pcm[8:1] <= din;
                    fm_pkg::pcm_en:  glb.pcm_en <= din[7];
                    fm_pkg::dactest: glb.pcm[0] <= din[3];   // ninth dac bit
                    fm_pkg::clk_n6:  cen_lim <= 3'd5;
                    fm_pkg::clk_n3:  cen_lim <= 3'd2;
                    fm_pkg::clk_n2:  cen_lim <= 3'd1;
                    8'hA4, 8'hA5, 8'hA6: fnum_hi_q <= din[5:0];
                    default: ;
                endcase
            end
        end
    end

    // update strobe, one cycle per data write
    always_ff @(posedge clk) begin
        if (rst)
            upd_target <= fm_pkg::upd_none;
        else if (data_wr)
            upd_target <= decode_upd(sel_reg);
        else
            upd_target <= fm_pkg::upd_none;
    end

    always_ff @(posedge clk) begin
        if (data_wr) begin
            upd_ch      <= {addr[1], sel_reg[1:0]};
            upd_op      <= sel_reg[3:2];
            upd_data    <= din;
            upd_fnum_hi <= fnum_hi_q;
        end
    end

    assign upd = '{target: upd_target, ch: upd_ch, op: upd_op,
                   data: upd_data, fnum_hi: upd_fnum_hi};

    // busy counts synth ticks after each data write
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy     <= 1'b1;
            busy_cnt <= '0;
        end else if (clk_en && busy) begin
            if (int'(busy_cnt) == fm_pkg::busy_ticks - 1)
                busy <= 1'b0;
            busy_cnt <= busy_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/fm_timers.sv
// fm timers a and b
`timescale 1ns/1ns
`default_nettype none

module fm_timers (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    clk_en,
    input  fm_pkg::fm_timer_cfg_t  tcfg,
    output logic                   flag_a,
    output logic                   flag_b,
    output logic                   irq_n
);

    logic [9:0] cnt_a;
    logic [7:0] cnt_b;
    logic [$clog2(fm_pkg::tb_prescale)-1:0] pre_b;
    logic       pre_wrap;
    logic       ovf_a;
    logic       ovf_b;

    assign pre_wrap = int'(pre_b) == fm_pkg::tb_prescale - 1;
    assign ovf_a    = clk_en & tcfg.load_a & (&cnt_a);
    assign ovf_b    = clk_en & tcfg.load_b & pre_wrap & (&cnt_b);

    // timer a, one step per tick
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_a <= '0;
        end else if (!tcfg.load_a) begin
            cnt_a <= tcfg.value_a;          // parked at start value while stopped
        end else if (clk_en) begin
            if (ovf_a)
                cnt_a <= tcfg.value_a;
            else
                cnt_a <= cnt_a + 10'd1;
        end
    end

    // timer b behind its prescaler
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_b <= '0;
            pre_b <= '0;
        end else if (!tcfg.load_b) begin
            cnt_b <= tcfg.value_b;
            pre_b <= '0;
        end else if (clk_en) begin
            pre_b <= pre_b + 1'b1;
            if (pre_wrap) begin
                if (ovf_b)
                    cnt_b <= tcfg.value_b;
                else
                    cnt_b <= cnt_b + 8'd1;
            end
        end
    end

    // a new overflow wins over a pending clear
    always_ff @(posedge clk) begin
        if (rst) begin
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else begin
            if (ovf_a && tcfg.irq_en_a)
                flag_a <= 1'b1;
            else if (tcfg.clr_a)
                flag_a <= 1'b0;

            if (ovf_b && tcfg.irq_en_b)
                flag_b <= 1'b1;
            else if (tcfg.clr_b)
                flag_b <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            irq_n <= 1'b1;
        else
            irq_n <= ~(flag_a | flag_b);
    end

endmodule

`default_nettype wire

// File: design/fm_reg_file.sv
// fm channel and operator parameter store
`timescale 1ns/1ns
`default_nettype none

module fm_reg_file (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 clk_en,
    input  fm_pkg::fm_update_t  upd,
    output fm_pkg::fm_slot_t    slot
);

    // operator storage, indexed by {ch, op}
    logic [6:0]  dt1_mul_q [fm_pkg::num_slot];
    logic [6:0]  tl_q      [fm_pkg::num_slot];
    logic [6:0]  ks_ar_q   [fm_pkg::num_slot];
    logic [5:0]  am_d1r_q  [fm_pkg::num_slot];
    logic [4:0]  d2r_q     [fm_pkg::num_slot];
    logic [7:0]  sl_rr_q   [fm_pkg::num_slot];
    logic [fm_pkg::num_slot-1:0] keyon_q;

    // channel storage
    logic [13:0] fnum_q       [fm_pkg::num_ch];   // {block, fnum}
    logic [5:0]  fb_alg_q     [fm_pkg::num_ch];
    logic [6:0]  lr_ams_pms_q [fm_pkg::num_ch];

    logic [2:0] wr_ch;
    logic [4:0] wr_slot;
    logic [2:0] kon_ch;
    logic       kon_ok;
    logic [2:0] seq_ch;
    logic [1:0] seq_op;
    logic [4:0] rd_slot;

    // bank code 0,1,2,4,5,6 to channel 0..5
    function automatic logic [2:0] ch_index(input logic [2:0] code);
        if (code[2])
            return {1'b0, code[1:0]} + 3'd3;
        else
            return {1'b0, code[1:0]};
    endfunction

    assign wr_ch   = ch_index(upd.ch);
    assign wr_slot = {wr_ch, upd.op[0], upd.op[1]};   // s1 s3 s2 s4 -> s1 s2 s3 s4
    assign kon_ch  = ch_index(upd.data[2:0]);
    assign kon_ok  = upd.data[1:0] != 2'b11;          // codes 3 and 7 ignored
    assign rd_slot = {seq_ch, seq_op};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < fm_pkg::num_slot; i++) begin
                dt1_mul_q[i] <= '0;
                tl_q[i]      <= '0;
                ks_ar_q[i]   <= '0;
                am_d1r_q[i]  <= '0;
                d2r_q[i]     <= '0;
                sl_rr_q[i]   <= '0;
            end
            for (int i = 0; i < fm_pkg::num_ch; i++) begin
                fnum_q[i]       <= '0;
                fb_alg_q[i]     <= '0;
                lr_ams_pms_q[i] <= '0;
            end
            keyon_q <= '0;
        end else begin
            case (upd.target)
                fm_pkg::upd_dt1_mul: dt1_mul_q[wr_slot] <= upd.data[6:0];
                fm_pkg::upd_tl:      tl_q[wr_slot] <= upd.data[6:0];
                fm_pkg::upd_ks_ar:   ks_ar_q[wr_slot] <= {upd.data[7:6], upd.data[4:0]};
                fm_pkg::upd_am_d1r:  am_d1r_q[wr_slot] <= {upd.data[7], upd.data[4:0]};
                fm_pkg::upd_d2r:     d2r_q[wr_slot] <= upd.data[4:0];
                fm_pkg::upd_sl_rr:   sl_rr_q[wr_slot] <= upd.data;
                fm_pkg::upd_fnum_lo: fnum_q[wr_ch] <= {upd.fnum_hi, upd.data};
                fm_pkg::upd_fb_alg:  fb_alg_q[wr_ch] <= upd.data[5:0];
                fm_pkg::upd_lr_ams_pms: begin
                    lr_ams_pms_q[wr_ch] <= {upd.data[7:4], upd.data[2:0]};
                end
                fm_pkg::upd_keyon: begin
                    if (kon_ok) begin
                        for (int op = 0; op < fm_pkg::num_op; op++)
                            keyon_q[{kon_ch, 2'(op)}] <= upd.data[4+op];   // mask s4..s1
                    end
                end
                default: ;
            endcase
        end
    end

    // slot sequencer, channel major
    always_ff @(posedge clk) begin
        if (rst) begin
            seq_ch <= '0;
            seq_op <= '0;
            slot   <= '0;
        end else if (clk_en) begin
            slot.ch    <= seq_ch;
            slot.op    <= seq_op;
            slot.keyon <= keyon_q[rd_slot];
            {slot.block, slot.fnum} <= fnum_q[seq_ch];
            {slot.dt1, slot.mul}    <= dt1_mul_q[rd_slot];
            slot.tl                 <= tl_q[rd_slot];
            {slot.ks, slot.ar}      <= ks_ar_q[rd_slot];
            {slot.amen, slot.d1r}   <= am_d1r_q[rd_slot];
            slot.d2r                <= d2r_q[rd_slot];
            {slot.sl, slot.rr}      <= sl_rr_q[rd_slot];
            {slot.fb, slot.alg}     <= fb_alg_q[seq_ch];
            {slot.rl, slot.ams, slot.pms} <= lr_ams_pms_q[seq_ch];

            if (int'(seq_op) == fm_pkg::num_op - 1) begin
                seq_op <= '0;
                if (int'(seq_ch) == fm_pkg::num_ch - 1)
                    seq_ch <= '0;
                else
                    seq_ch <= seq_ch + 3'd1;
            end else begin
                seq_op <= seq_op + 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/fm_top.sv
// fm register interface top
`timescale 1ns/1ns
`default_nettype none

module fm_top (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 cen,
    input  wire [7:0]           din,
    input  wire [1:0]           addr,
    input  wire                 write,
    output wire                 busy,
    output wire                 clk_en,
    output wire                 flag_a,
    output wire                 flag_b,
    output wire                 irq_n,
    output fm_pkg::fm_global_t  glb,
    output fm_pkg::fm_slot_t    slot
);

    fm_pkg::fm_update_t    upd;
    fm_pkg::fm_timer_cfg_t tcfg;

    fm_mmr u_mmr (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .din    (din),
        .addr   (addr),
        .write  (write),
        .clk_en (clk_en),
        .busy   (busy),
        .upd    (upd),
        .tcfg   (tcfg),
        .glb    (glb)
    );

    fm_timers u_timers (
        .clk    (clk),
        .rst    (rst),
        .clk_en (clk_en),
        .tcfg   (tcfg),
        .flag_a (flag_a),
        .flag_b (flag_b),
        .irq_n  (irq_n)
    );

    fm_reg_file u_reg_file (
        .clk    (clk),
        .rst    (rst),
        .clk_en (clk_en),
        .upd    (upd),
        .slot   (slot)
    );

endmodule

`default_nettype wire

// File: verification/fm_tb_tasks.svh
// testbench host and tick tasks
`ifndef FM_TB_TASKS_SVH
`define FM_TB_TASKS_SVH

// select a register, then write its data
task automatic send_write(input logic [7:0] reg_addr, input logic [7:0] data, input logic bank);
    @(posedge clk);
    addr  <= {bank, 1'b0};
    din   <= reg_addr;
    write <= 1'b1;
    @(posedge clk);
    addr <= {bank, 1'b1};
    din  <= data;
    @(posedge clk);
    write <= 1'b0;              // data write sampled at this edge
    model_write(reg_addr, data, bank);
endtask

// full host access, busy length checked in synth ticks
task automatic write_reg(input logic [7:0] reg_addr, input logic [7:0] data, input logic bank);
    int ticks;
    int cycles;
    ticks = 0;
    cycles = 0;
    send_write(reg_addr, data, bank);
    @(negedge clk);
    assert (busy) else begin
        fail_cnt++;
        $display("%s: busy did not rise after the data write to %h", test_name, reg_addr);
    end
    while (busy && cycles < busy_limit) begin
        if (clk_en)
            ticks++;
        @(negedge clk);
        cycles++;
    end
    assert (ticks == fm_pkg::busy_ticks) else begin
        mismatch_cnt++;
        $display("mismatch %s: busy ticks expected %0d actual %0d", test_name,
                 fm_pkg::busy_ticks, ticks);
    end
endtask

task automatic wait_not_busy();
    int cycles;
    cycles = 0;
    do begin
        @(negedge clk);
        cycles++;
    end while (busy && cycles < busy_limit);
    if (busy) begin
        fail_cnt++;
        $display("%s: busy stayed high for %0d cycles", test_name, cycles);
    end
endtask

task automatic wait_ticks(input int n);
    int seen;
    seen = 0;
    while (seen < n) begin
        @(negedge clk);
        if (clk_en)
            seen++;
    end
endtask

// clk cycles from one clk_en pulse to the next
task automatic measure_gap(input int expected);
    int gap;
    gap = 0;
    do @(negedge clk); while (!clk_en);
    do begin
        @(negedge clk);
        gap++;
    end while (!clk_en);
    assert (gap == expected) else begin
        mismatch_cnt++;
        $display("mismatch %s: clk_en gap expected %0d actual %0d", test_name, expected, gap);
    end
endtask

// ticks from a timer load until its flag shows
task automatic ticks_to_flag(input logic use_b, input int expected);
    int ticks;
    int cycles;
    ticks = 0;
    cycles = 0;
    @(negedge clk);
    while (!(use_b ? flag_b : flag_a) && cycles < busy_limit) begin
        if (clk_en)
            ticks++;
        @(negedge clk);
        cycles++;
    end
    assert (ticks == expected) else begin
        mismatch_cnt++;
        $display("mismatch %s: ticks to flag expected %0d actual %0d", test_name, expected, ticks);
    end
    @(negedge clk);
    assert (!irq_n) else begin
        fail_cnt++;
        $display("%s: irq_n is not low while a flag is set", test_name);
    end
endtask

`endif

// File: verification/fm_tb.sv
// fm register interface testbench
`timescale 1ns/1ns
`default_nettype none

module fm_tb;

    localparam int busy_limit   = (fm_pkg::busy_ticks + 2) * 6;   // cycles at divide by 6
    localparam int max_writes   = 100;
    localparam int write_cycles = 3 + (fm_pkg::busy_ticks + 1) * 6;
    localparam int wd_cycles    = 3 * (max_writes * write_cycles + 2 * busy_limit);

    logic       clk = 1'b0;
    logic       rst;
    logic       cen;
    logic [7:0] din;
    logic [1:0] addr;
    logic       write;
    wire        busy;
    wire        clk_en;
    wire        flag_a;
    wire        flag_b;
    wire        irq_n;
    fm_pkg::fm_global_t glb;
    fm_pkg::fm_slot_t   slot;

    fm_pkg::fm_slot_t   model [fm_pkg::num_slot];   // expected slot contents
    fm_pkg::fm_global_t glb_exp;
    logic [5:0] fnum_hi;        // {block, fnum[10:8]} latch
    int         mismatch_cnt = 0;
    int         fail_cnt = 0;
    int         exp_idx;
    logic       tick_seen;
    integer     seed = 93;
    string      test_name = "reset";

    always #20 clk = ~clk;

    fm_top UUT (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .din    (din),
        .addr   (addr),
        .write  (write),
        .busy   (busy),
        .clk_en (clk_en),
        .flag_a (flag_a),
        .flag_b (flag_b),
        .irq_n  (irq_n),
        .glb    (glb),
        .slot   (slot)
    );

    function automatic void model_write(input logic [7:0] r, input logic [7:0] d,
                                        input logic bank);
        int ch;
        int op;
        int kch;
        int k;
        ch = (bank ? 3 : 0) + int'(r[1:0]);
        case (r[3:2])
            2'd0: op = 0;       // S1
            2'd1: op = 2;       // S3
            2'd2: op = 1;       // S2
            default: op = 3;    // S4
        endcase
        if (r[7:4] == 4'h2) begin
            case (r)
                8'h22: {glb_exp.lfo_en, glb_exp.lfo_freq} = d[3:0];
                8'h2A: glb_exp.pcm[8:1] = d;
                8'h2B: glb_exp.pcm_en = d[7];
                8'h2C: glb_exp.pcm[0] = d[3];
                8'h28: begin
                    kch = (d[2] ? 3 : 0) + int'(d[1:0]);
                    if (d[1:0] != 2'b11) begin
                        for (k = 0; k < 4; k++)
                            model[kch * 4 + k].keyon = d[4 + k];
                    end
                end
                default: ;
            endcase
        end else if (r[1:0] != 2'b11) begin
            case (r[7:4])
                4'h3: {model[ch * 4 + op].dt1, model[ch * 4 + op].mul} = d[6:0];
                4'h4: model[ch * 4 + op].tl = d[6:0];
                4'h5: {model[ch * 4 + op].ks, model[ch * 4 + op].ar} = {d[7:6], d[4:0]};
                4'h6: {model[ch * 4 + op].amen, model[ch * 4 + op].d1r} = {d[7], d[4:0]};
                4'h7: model[ch * 4 + op].d2r = d[4:0];
                4'h8: {model[ch * 4 + op].sl, model[ch * 4 + op].rr} = d;
                4'hA: begin
                    if (r[3:2] == 2'd1)
                        fnum_hi = d[5:0];
                    for (k = 0; k < 4 && r[3:2] == 2'd0; k++)
                        {model[ch * 4 + k].block, model[ch * 4 + k].fnum} = {fnum_hi, d};
                end
                4'hB: begin
                    for (k = 0; k < 4 && r[3:2] == 2'd0; k++)
                        {model[ch * 4 + k].fb, model[ch * 4 + k].alg} = d[5:0];
                    for (k = 0; k < 4 && r[3:2] == 2'd1; k++)
                        {model[ch * 4 + k].rl, model[ch * 4 + k].ams, model[ch * 4 + k].pms}
                            = {d[7:4], d[2:0]};
                end
                default: ;
            endcase
        end
    endfunction

    `include "fm_tb_tasks.svh"

    // slot order every tick, slot contents once the writes have settled
    always @(negedge clk) begin
        if (rst) begin
            exp_idx = 0;
            tick_seen = 1'b0;
        end else begin
            if (tick_seen) begin
                assert (int'(slot.ch) * 4 + int'(slot.op) == exp_idx) else begin
                    mismatch_cnt++;
                    $display("mismatch %s: slot index expected %0d actual %0d", test_name,
                             exp_idx, int'(slot.ch) * 4 + int'(slot.op));
                end
                if (!busy) begin
                    assert (slot == model[exp_idx]) else begin
                        mismatch_cnt++;
                        $display("mismatch %s: slot %0d expected %h actual %h", test_name,
                                 exp_idx, model[exp_idx], slot);
                    end
                end
                exp_idx = (exp_idx + 1) % fm_pkg::num_slot;
            end
            tick_seen = clk_en;
            assert (glb == glb_exp) else begin
                mismatch_cnt++;
                $display("mismatch %s: glb expected %h actual %h", test_name, glb_exp, glb);
            end
        end
    end

    initial begin
        int hi;
        int b;
        int c;
        logic [3:0] kmask;
        rst = 1'b1;
        cen = 1'b1;
        din = '0;
        addr = '0;
        write = 1'b0;
        glb_exp = '0;
        fnum_hi = '0;
        for (int i = 0; i < fm_pkg::num_slot; i++) begin
            model[i] = '0;
            model[i].ch = 3'(i / 4);
            model[i].op = 2'(i % 4);
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!busy && irq_n && !flag_a && !flag_b) else begin
            fail_cnt++;
            $display("reset: busy, irq_n or a timer flag is not at its idle value");
        end
        wait_ticks(fm_pkg::num_slot + 2);

        test_name = "divider";
        measure_gap(6);
        write_reg(8'h2F, 8'h00, 1'b0);
        measure_gap(2);
        write_reg(8'h2E, 8'h00, 1'b0);
        measure_gap(3);
        write_reg(8'h2D, 8'h00, 1'b0);
        measure_gap(6);

        test_name = "global";
        repeat (2) begin
            write_reg(8'h22, 8'($random(seed)), 1'b0);
            write_reg(8'h2A, 8'($random(seed)), 1'b0);
            write_reg(8'h2B, 8'($random(seed)), 1'b0);
            write_reg(8'h2C, 8'($random(seed)), 1'b0);
        end

        test_name = "operator";
        repeat (36) begin
            hi = 3 + int'($unsigned($random(seed)) % 6);
            write_reg({4'(hi), 2'($random(seed)), 2'($unsigned($random(seed)) % 3)},
                      8'($random(seed)), 1'($random(seed)));
        end

        test_name = "channel";
        for (b = 0; b < 2; b++) begin
            for (c = 0; c < 3; c++) begin
                write_reg(8'hA4 + 8'(c), 8'($random(seed)), 1'(b));
                write_reg(8'hA0 + 8'(c), 8'($random(seed)), 1'(b));
                write_reg(8'hB0 + 8'(c), 8'($random(seed)), 1'(b));
                write_reg(8'hB4 + 8'(c), 8'($random(seed)), 1'(b));
            end
        end

        test_name = "keyon";
        for (c = 0; c < 8; c++) begin
            if (c % 4 != 3)
                write_reg(8'h28, {4'($random(seed)), 4'(c)}, 1'b0);
        end
        // invalid codes go last and carry the inverse of channel 3's mask
        kmask = ~{model[15].keyon, model[14].keyon, model[13].keyon, model[12].keyon};
        write_reg(8'h28, {kmask, 4'd3}, 1'b0);
        write_reg(8'h28, {kmask, 4'd7}, 1'b0);

        test_name = "timer a";
        write_reg(8'h24, 8'hFE, 1'b0);     // 1016
        write_reg(8'h25, 8'h00, 1'b0);
        send_write(8'h27, 8'h05, 1'b0);    // load and enable a
        ticks_to_flag(1'b0, 8);
        wait_not_busy();
        write_reg(8'h27, 8'h10, 1'b0);     // stop and clear a
        assert (!flag_a && irq_n) else begin
            fail_cnt++;
            $display("timer a: flag_a or irq_n did not clear");
        end

        test_name = "timer b";
        write_reg(8'h26, 8'hFE, 1'b0);
        send_write(8'h27, 8'h0A, 1'b0);    // load and enable b
        ticks_to_flag(1'b1, 32);
        wait_not_busy();
        write_reg(8'h27, 8'h20, 1'b0);
        assert (!flag_b && irq_n) else begin
            fail_cnt++;
            $display("timer b: flag_b or irq_n did not clear");
        end
        wait_ticks(fm_pkg::num_slot + 1);

        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("timeout: test sequence did not finish within %0d cycles", wd_cycles);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+verification
design/fm_pkg.sv
design/fm_mmr.sv
design/fm_timers.sv
design/fm_reg_file.sv
design/fm_top.sv
verification/fm_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the fm register interface testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module fm_tb -f build.f -o fm_sim

out=$(./obj_dir/fm_sim)
echo "$out"

if echo "$out" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1
